/* design/correlator_pkg.sv */
`default_nettype none

package correlator_pkg;

   // ----------------------------------------------------------------------
   // Sizes
   // ----------------------------------------------------------------------
   localparam int NUM_ANT   = 4;
   localparam int NUM_PAIRS = 6;
   localparam int ACC_W     = 16;
   localparam int DATA_W    = 16;
   localparam int ADDR_W    = 5;
   localparam int CLOG_W    = 4;
   localparam int FRAME_W   = 8;

   // Sample counter wide enough for the largest frame
   localparam int CNT_W = 1 << CLOG_W;

   // Sine select bit inside a visibility address
   localparam int VIS_SIN_BIT = 3;

   // ----------------------------------------------------------------------
   // Types
   // ----------------------------------------------------------------------
   typedef logic [NUM_ANT-1:0]       ant_t;
   typedef logic signed [ACC_W-1:0]  vis_t;
   typedef logic [DATA_W-1:0]        data_t;
   typedef logic [ADDR_W-1:0]        addr_t;
   typedef logic [CLOG_W-1:0]        clog_t;
   typedef logic [FRAME_W-1:0]       frame_t;

   typedef enum logic {
      BUS_IDLE,
      BUS_ACK
   } bus_state_t;

   // 16 samples per frame out of reset
   localparam clog_t COUNT_LOG_RESET = 4'd4;

   // Address map
   localparam addr_t ADR_COS_BASE  = 5'd0;
   localparam addr_t ADR_SIN_BASE  = 5'd8;
   localparam addr_t ADR_COUNT_LOG = 5'd16;
   localparam addr_t ADR_STATUS    = 5'd17;

   // Antenna pair table, (0,1) (0,2) (0,3) (1,2) (1,3) (2,3)
   localparam int PAIR_A [NUM_PAIRS] = '{0, 0, 0, 1, 1, 2};
   localparam int PAIR_B [NUM_PAIRS] = '{1, 2, 3, 2, 3, 3};

endpackage

`default_nettype wire

/* design/correlator_block.sv */
`timescale 1ns/1ns
`default_nettype none

module correlator_block (
   input  wire                          clk_i,
   input  wire                          rst,
   input  wire                          en_i,
   input  wire correlator_pkg::ant_t    re_i,
   input  wire correlator_pkg::ant_t    im_i,
   input  wire correlator_pkg::clog_t   count_log_i,
   input  wire                          restart_i,
   output logic                         frame_done_o,
   output correlator_pkg::vis_t         cos_sums_o [correlator_pkg::NUM_PAIRS],
   output correlator_pkg::vis_t         sin_sums_o [correlator_pkg::NUM_PAIRS],
   output logic                         ovf_cos_o,
   output logic                         ovf_sin_o
);

   import correlator_pkg::*;

   // Running sums, one pair each
   vis_t acc_cos [NUM_PAIRS];
   vis_t acc_sin [NUM_PAIRS];

   // Per-pair step and widened sum
   logic signed [2:0] c_step [NUM_PAIRS];
   logic signed [2:0] s_step [NUM_PAIRS];
   logic [ACC_W:0]    c_sum [NUM_PAIRS];
   logic [ACC_W:0]    s_sum [NUM_PAIRS];
   logic [NUM_PAIRS-1:0] ovf_cos_p;
   logic [NUM_PAIRS-1:0] ovf_sin_p;

   // Frame counting
   logic [CNT_W-1:0] smp_cnt;
   logic [CNT_W-1:0] cnt_max;
   logic             take;
   logic             frame_last;

   // Sum of two +-1 terms, each given as 1 for +1
   function automatic logic signed [2:0] step(input logic p, input logic q);
      if (p && q)
         return 3'sd2;
      else if (!p && !q)
         return -3'sd2;
      return 3'sd0;
   endfunction

   // ----------------------------------------------------------------------
   // Products and sums
   // ----------------------------------------------------------------------
   always_comb begin
      for (int k = 0; k < NUM_PAIRS; k++) begin
         // cos: re_a*re_b + im_a*im_b
         c_step[k] = step(~(re_i[PAIR_A[k]] ^ re_i[PAIR_B[k]]),
                          ~(im_i[PAIR_A[k]] ^ im_i[PAIR_B[k]]));
         // sin: im_a*re_b - re_a*im_b, negated product is the xor
         s_step[k] = step(~(im_i[PAIR_A[k]] ^ re_i[PAIR_B[k]]),
                          re_i[PAIR_A[k]] ^ im_i[PAIR_B[k]]);
         // One guard bit on top
         c_sum[k] = {acc_cos[k][ACC_W-1], acc_cos[k]}
                  + {{(ACC_W-2){c_step[k][2]}}, c_step[k]};
         s_sum[k] = {acc_sin[k][ACC_W-1], acc_sin[k]}
                  + {{(ACC_W-2){s_step[k][2]}}, s_step[k]};
         cos_sums_o[k] = c_sum[k][ACC_W-1:0];
         sin_sums_o[k] = s_sum[k][ACC_W-1:0];
         // Guard and sign bits disagree on leaving the range
         ovf_cos_p[k] = c_sum[k][ACC_W] ^ c_sum[k][ACC_W-1];
         ovf_sin_p[k] = s_sum[k][ACC_W] ^ s_sum[k][ACC_W-1];
      end
   end

   // 2^count_log - 1
   assign cnt_max = ~({CNT_W{1'b1}} << count_log_i);

   // Sample dropped on restart
   assign take       = en_i && !restart_i;
   assign frame_last = take && (smp_cnt == cnt_max);

   assign frame_done_o = frame_last;
   assign ovf_cos_o    = take && (|ovf_cos_p);
   assign ovf_sin_o    = take && (|ovf_sin_p);

   // ----------------------------------------------------------------------
   // Accumulators and sample counter
   // ----------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst || restart_i) begin
         smp_cnt <= '0;
         for (int k = 0; k < NUM_PAIRS; k++) begin
            acc_cos[k] <= '0;
            acc_sin[k] <= '0;
         end
      end else if (take) begin
         if (frame_last) begin
            // Sums leave through the outputs, start over
            smp_cnt <= '0;
            for (int k = 0; k < NUM_PAIRS; k++) begin
               acc_cos[k] <= '0;
               acc_sin[k] <= '0;
            end
         end else begin
            smp_cnt <= smp_cnt + 1'b1;
            // Wraps on overflow
            for (int k = 0; k < NUM_PAIRS; k++) begin
               acc_cos[k] <= c_sum[k][ACC_W-1:0];
               acc_sin[k] <= s_sum[k][ACC_W-1:0];
            end
         end
      end
   end

endmodule

`default_nettype wire

/* design/visibility_bank.sv */
`timescale 1ns/1ns
`default_nettype none

module visibility_bank (
   input  wire                          clk_i,
   input  wire                          rst,
   input  wire                          frame_done_i,
   input  wire correlator_pkg::vis_t    cos_sums_i [correlator_pkg::NUM_PAIRS],
   input  wire correlator_pkg::vis_t    sin_sums_i [correlator_pkg::NUM_PAIRS],
   input  wire correlator_pkg::addr_t   vis_addr_i,
   output correlator_pkg::vis_t         vis_rd_o,
   output correlator_pkg::frame_t       frame_count_o
);

   import correlator_pkg::*;

   // Last completed frame
   vis_t cos_bank [NUM_PAIRS];
   vis_t sin_bank [NUM_PAIRS];

   // Address fields
   logic [VIS_SIN_BIT-1:0] pair_idx;
   logic                   sin_sel;
   logic                   in_range;

   // ----------------------------------------------------------------------
   // Capture on frame end
   // ----------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst) begin
         frame_count_o <= '0;
         for (int k = 0; k < NUM_PAIRS; k++) begin
            cos_bank[k] <= '0;
            sin_bank[k] <= '0;
         end
      end else if (frame_done_i) begin
         // 8-bit wrap
         frame_count_o <= frame_count_o + 1'b1;
         for (int k = 0; k < NUM_PAIRS; k++) begin
            cos_bank[k] <= cos_sums_i[k];
            sin_bank[k] <= sin_sums_i[k];
         end
      end
   end

   // ----------------------------------------------------------------------
   // Read port
   // ----------------------------------------------------------------------
   assign pair_idx = vis_addr_i[VIS_SIN_BIT-1:0];
   assign sin_sel  = vis_addr_i[VIS_SIN_BIT];
   assign in_range = (vis_addr_i[ADDR_W-1:VIS_SIN_BIT+1] == '0) && (pair_idx < NUM_PAIRS);

   always_comb begin
      vis_rd_o = '0;
      // Pair 6 and 7 read zero
      if (in_range) begin
         if (sin_sel)
            vis_rd_o = sin_bank[pair_idx];
         else
            vis_rd_o = cos_bank[pair_idx];
      end
   end

endmodule

`default_nettype wire

/* design/correlator_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module correlator_regs (
   input  wire                          clk_i,
   input  wire                          rst,
   input  wire                          reg_we_i,
   input  wire                          reg_sel_i,
   input  wire correlator_pkg::data_t   wr_data_i,
   input  wire                          ovf_cos_i,
   input  wire                          ovf_sin_i,
   input  wire correlator_pkg::frame_t  frame_count_i,
   output correlator_pkg::clog_t        count_log_o,
   output logic                         restart_o,
   output correlator_pkg::data_t        status_o,
   output logic                         overflow_cos_o,
   output logic                         overflow_sin_o
);

   import correlator_pkg::*;

   // Write strobes per register
   logic cnt_wr;
   logic sts_wr;

   assign cnt_wr = reg_we_i && !reg_sel_i;
   assign sts_wr = reg_we_i && reg_sel_i;

   // Clears the core at the same edge as the write
   assign restart_o = cnt_wr;

   // ----------------------------------------------------------------------
   // count_log and overflow flags
   // ----------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst) begin
         count_log_o    <= COUNT_LOG_RESET;
         overflow_cos_o <= 1'b0;
         overflow_sin_o <= 1'b0;
      end else begin
         if (cnt_wr)
            count_log_o <= wr_data_i[CLOG_W-1:0];
         // New overflow beats the clear
         if (ovf_cos_i)
            overflow_cos_o <= 1'b1;
         else if (sts_wr)
            overflow_cos_o <= 1'b0;
         if (ovf_sin_i)
            overflow_sin_o <= 1'b1;
         else if (sts_wr)
            overflow_sin_o <= 1'b0;
      end
   end

   // Frame count high, flags low
   assign status_o = {frame_count_i, {(DATA_W-FRAME_W-2){1'b0}}, overflow_sin_o, overflow_cos_o};

endmodule

`default_nettype wire

/* design/bus_interface.sv */
`timescale 1ns/1ns
`default_nettype none

module bus_interface (
   input  wire                          clk_i,
   input  wire                          rst,
   input  wire                          cyc_i,
   input  wire                          stb_i,
   input  wire                          we_i,
   input  wire correlator_pkg::addr_t   adr_i,
   input  wire correlator_pkg::data_t   dat_i,
   output logic                         ack_o,
   output correlator_pkg::data_t        dat_o,
   output logic                         reg_we_o,
   output logic                         reg_sel_o,
   output correlator_pkg::data_t        wr_data_o,
   output correlator_pkg::addr_t        vis_addr_o,
   input  wire correlator_pkg::vis_t    vis_rd_i,
   input  wire correlator_pkg::clog_t   count_log_i,
   input  wire correlator_pkg::data_t   status_i
);

   import correlator_pkg::*;

   bus_state_t state;
   logic       start;

   // Decode
   addr_t cos_off;
   addr_t sin_off;
   logic  cos_hit;
   logic  sin_hit;
   logic  cnt_hit;
   logic  sts_hit;
   data_t rd_word;

   // ----------------------------------------------------------------------
   // Address map
   // ----------------------------------------------------------------------
   // Offsets wrap below the base, so one compare covers the range
   assign cos_off = adr_i - ADR_COS_BASE;
   assign sin_off = adr_i - ADR_SIN_BASE;
   assign cos_hit = (cos_off < NUM_PAIRS);
   assign sin_hit = (sin_off < NUM_PAIRS);
   assign cnt_hit = (adr_i == ADR_COUNT_LOG);
   assign sts_hit = (adr_i == ADR_STATUS);

   always_comb begin
      vis_addr_o = '0;
      if (sin_hit) begin
         vis_addr_o = sin_off;
         vis_addr_o[VIS_SIN_BIT] = 1'b1;
      end else if (cos_hit) begin
         vis_addr_o = cos_off;
      end
   end

   // Read mux, unmapped reads zero
   always_comb begin
      rd_word = '0;
      if (cos_hit || sin_hit)
         rd_word = data_t'(vis_rd_i);
      else if (cnt_hit)
         rd_word = data_t'(count_log_i);
      else if (sts_hit)
         rd_word = status_i;
   end

   // ----------------------------------------------------------------------
   // Handshake
   // ----------------------------------------------------------------------
   assign ack_o = (state == BUS_ACK);
   assign start = cyc_i && stb_i && !ack_o;

   always_ff @(posedge clk_i) begin
      if (rst)
         state <= BUS_IDLE;
      else begin
         case (state)
            BUS_IDLE: if (start) state <= BUS_ACK;
            BUS_ACK:  state <= BUS_IDLE;
         endcase
      end
   end

   // Read data lines up with ack
   always_ff @(posedge clk_i) begin
      if (start)
         dat_o <= rd_word;
   end

   // Register writes land on the edge that raises ack
   assign reg_we_o  = start && we_i && (cnt_hit || sts_hit);
   assign reg_sel_o = sts_hit;
   assign wr_data_o = dat_i;

endmodule

`default_nettype wire

/* design/tart_correlator.sv */
`timescale 1ns/1ns
`default_nettype none

module tart_correlator (
   input  wire                          clk_i,
   input  wire                          rst,
   // Bus
   input  wire                          cyc_i,
   input  wire                          stb_i,
   input  wire                          we_i,
   input  wire correlator_pkg::addr_t   adr_i,
   input  wire correlator_pkg::data_t   dat_i,
   output logic                         ack_o,
   output correlator_pkg::data_t        dat_o,
   // Samples
   input  wire                          en_i,
   input  wire correlator_pkg::ant_t    re_i,
   input  wire correlator_pkg::ant_t    im_i,
   // Sticky flags
   output logic                         overflow_cos_o,
   output logic                         overflow_sin_o
);

   import correlator_pkg::*;

   // ----------------------------------------------------------------------
   // Interconnect
   // ----------------------------------------------------------------------
   logic   reg_we;
   logic   reg_sel;
   data_t  wr_data;
   addr_t  vis_addr;
   vis_t   vis_rd;
   clog_t  count_log;
   data_t  status;
   logic   restart;
   logic   ovf_cos;
   logic   ovf_sin;
   logic   frame_done;
   frame_t frame_count;
   vis_t   cos_sums [NUM_PAIRS];
   vis_t   sin_sums [NUM_PAIRS];

   bus_interface u_bus (
      .clk_i       (clk_i),
      .rst         (rst),
      .cyc_i       (cyc_i),
      .stb_i       (stb_i),
      .we_i        (we_i),
      .adr_i       (adr_i),
      .dat_i       (dat_i),
      .ack_o       (ack_o),
      .dat_o       (dat_o),
      .reg_we_o    (reg_we),
      .reg_sel_o   (reg_sel),
      .wr_data_o   (wr_data),
      .vis_addr_o  (vis_addr),
      .vis_rd_i    (vis_rd),
      .count_log_i (count_log),
      .status_i    (status)
   );

   // Registers steer the core
   correlator_regs u_regs (
      .clk_i          (clk_i),
      .rst            (rst),
      .reg_we_i       (reg_we),
      .reg_sel_i      (reg_sel),
      .wr_data_i      (wr_data),
      .ovf_cos_i      (ovf_cos),
      .ovf_sin_i      (ovf_sin),
      .frame_count_i  (frame_count),
      .count_log_o    (count_log),
      .restart_o      (restart),
      .status_o       (status),
      .overflow_cos_o (overflow_cos_o),
      .overflow_sin_o (overflow_sin_o)
   );

   correlator_block u_core (
      .clk_i        (clk_i),
      .rst          (rst),
      .en_i         (en_i),
      .re_i         (re_i),
      .im_i         (im_i),
      .count_log_i  (count_log),
      .restart_i    (restart),
      .frame_done_o (frame_done),
      .cos_sums_o   (cos_sums),
      .sin_sums_o   (sin_sums),
      .ovf_cos_o    (ovf_cos),
      .ovf_sin_o    (ovf_sin)
   );

   visibility_bank u_bank (
      .clk_i         (clk_i),
      .rst           (rst),
      .frame_done_i  (frame_done),
      .cos_sums_i    (cos_sums),
      .sin_sums_i    (sin_sums),
      .vis_addr_i    (vis_addr),
      .vis_rd_o      (vis_rd),
      .frame_count_o (frame_count)
   );

endmodule

`default_nettype wire

/* tests/tb_correlator.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_correlator;

   import correlator_pkg::*;

   localparam int CLK_PERIOD  = 100;
   localparam int BUS_TIMEOUT = 8;
   localparam int NUM_ROWS    = 7;

   // Sample modes
   localparam logic [1:0] MODE_ONES = 2'd0;
   localparam logic [1:0] MODE_INV0 = 2'd1;
   localparam logic [1:0] MODE_LFSR = 2'd2;
   localparam logic [1:0] MODE_NONE = 2'd3;

   // Pair order (0,1) (0,2) (0,3) (1,2) (1,3) (2,3)
   localparam int ANT_A [NUM_PAIRS] = '{0, 0, 0, 1, 1, 2};
   localparam int ANT_B [NUM_PAIRS] = '{1, 2, 3, 2, 3, 3};

   // One row per test step with ovf as {sin, cos}
   typedef struct packed {
      logic [3:0] clog;
      logic [7:0] frames;
      logic [1:0] mode;
      logic [3:0] gap;
      logic [1:0] ovf;
   } row_t;

   localparam row_t ROWS [NUM_ROWS] = '{
      '{4'd4,  8'd2, MODE_ONES, 4'b1111, 2'b00},
      '{4'd3,  8'd3, MODE_INV0, 4'b1011, 2'b00},
      '{4'd5,  8'd2, MODE_LFSR, 4'b1111, 2'b00},
      '{4'd6,  8'd1, MODE_LFSR, 4'b0110, 2'b00},
      '{4'd2,  8'd5, MODE_LFSR, 4'b1101, 2'b00},
      '{4'd15, 8'd1, MODE_ONES, 4'b1111, 2'b01},
      '{4'd4,  8'd2, MODE_INV0, 4'b0101, 2'b00}
   };

   logic  clk_i;
   logic  rst;
   logic  cyc_i;
   logic  stb_i;
   logic  we_i;
   addr_t adr_i;
   data_t dat_i;
   logic  ack_o;
   data_t dat_o;
   logic  en_i;
   ant_t  re_i;
   ant_t  im_i;
   logic  overflow_cos_o;
   logic  overflow_sin_o;

   // Reference model state
   int   m_cos [NUM_PAIRS];
   int   m_sin [NUM_PAIRS];
   int   exp_cos [NUM_PAIRS];
   int   exp_sin [NUM_PAIRS];
   int   m_cnt;
   int   m_frames;
   logic m_ovf_cos;
   logic m_ovf_sin;
   logic saw_neg_sin;

   logic [31:0] lfsr_state = 32'h3f5b7b89;

   tart_correlator DUT (
      .clk_i          (clk_i),
      .rst            (rst),
      .cyc_i          (cyc_i),
      .stb_i          (stb_i),
      .we_i           (we_i),
      .adr_i          (adr_i),
      .dat_i          (dat_i),
      .ack_o          (ack_o),
      .dat_o          (dat_o),
      .en_i           (en_i),
      .re_i           (re_i),
      .im_i           (im_i),
      .overflow_cos_o (overflow_cos_o),
      .overflow_sin_o (overflow_sin_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   // ----------------------------------------------------------------------
   // Helpers
   // ----------------------------------------------------------------------
   task automatic stop_on_failure();
      $display("Testbench failed");
      $fatal(1, "stopping at first failure");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
         stop_on_failure();
      end
   endtask

   // Galois LFSR stepped once per bit
   function automatic logic next_rand_bit();
      logic b;
      b = lfsr_state[0];
      lfsr_state = (lfsr_state >> 1) ^ (b ? 32'h80200003 : 32'h0);
      return b;
   endfunction

   // Worst case cycle count as gaps stretch the sample phase
   function automatic longint run_cycles();
      longint total;
      total = 1000;
      for (int r = 0; r < NUM_ROWS; r++) begin
         total += ((longint'(ROWS[r].frames) << ROWS[r].clog) * 4)
                  / longint'($countones(ROWS[r].gap)) + 400;
      end
      return total;
   endfunction

   // Bit 1 is +1 and bit 0 is -1
   function automatic int prod(input logic x, input logic y);
      return (x == y) ? 1 : -1;
   endfunction

   function automatic int wrap16(input int v);
      logic signed [15:0] w;
      w = v[15:0];
      return int'(w);
   endfunction

   // ----------------------------------------------------------------------
   // Bus cycles
   // ----------------------------------------------------------------------
   task automatic bus_cycle(input logic we, input addr_t adr, input data_t wdata,
                            output data_t rdata);
      int waited;
      waited = 0;
      @(negedge clk_i);
      cyc_i = 1'b1;
      stb_i = 1'b1;
      we_i  = we;
      adr_i = adr;
      dat_i = wdata;
      @(negedge clk_i);
      while (!ack_o) begin
         waited++;
         if (waited > BUS_TIMEOUT) begin
            $display("bus cycle to address %0d got no ack", adr);
            stop_on_failure();
         end
         @(negedge clk_i);
      end
      rdata = dat_o;
      cyc_i = 1'b0;
      stb_i = 1'b0;
      we_i  = 1'b0;
   endtask

   task automatic bus_read(input addr_t adr, output data_t data);
      bus_cycle(1'b0, adr, '0, data);
   endtask

   task automatic bus_write(input addr_t adr, input data_t data);
      data_t unused;
      bus_cycle(1'b1, adr, data, unused);
   endtask

   // ----------------------------------------------------------------------
   // Reference model
   // ----------------------------------------------------------------------
   task automatic model_restart();
      m_cnt = 0;
      for (int k = 0; k < NUM_PAIRS; k++) begin
         m_cos[k] = 0;
         m_sin[k] = 0;
      end
   endtask

   task automatic model_sample(input ant_t re, input ant_t im, input logic [3:0] clog);
      int a;
      int b;
      int nc;
      int ns;
      for (int k = 0; k < NUM_PAIRS; k++) begin
         a  = ANT_A[k];
         b  = ANT_B[k];
         nc = m_cos[k] + prod(re[a], re[b]) + prod(im[a], im[b]);
         ns = m_sin[k] + prod(im[a], re[b]) - prod(re[a], im[b]);
         // Signed 16-bit range
         if (nc > 32767 || nc < -32768)
            m_ovf_cos = 1'b1;
         if (ns > 32767 || ns < -32768)
            m_ovf_sin = 1'b1;
         m_cos[k] = wrap16(nc);
         m_sin[k] = wrap16(ns);
      end
      m_cnt++;
      // Frame end moves sums to the bank
      if (m_cnt == (1 << clog)) begin
         for (int k = 0; k < NUM_PAIRS; k++) begin
            exp_cos[k] = m_cos[k];
            exp_sin[k] = m_sin[k];
         end
         model_restart();
         m_frames++;
      end
   endtask

   task automatic make_sample(input logic [1:0] mode, output ant_t re, output ant_t im);
      case (mode)
         MODE_ONES: begin
            re = '1;
            im = '1;
         end
         MODE_INV0: begin
            re = 4'b1110;
            im = 4'b1110;
         end
         default: begin
            for (int i = 0; i < NUM_ANT; i++)
               re[i] = next_rand_bit();
            for (int i = 0; i < NUM_ANT; i++)
               im[i] = next_rand_bit();
         end
      endcase
   endtask

   // ----------------------------------------------------------------------
   // Row stimulus and readback
   // ----------------------------------------------------------------------
   task automatic feed_row(input row_t row);
      int   need;
      int   got;
      int   cyc;
      ant_t re;
      ant_t im;
      need = int'(row.frames) << row.clog;
      got  = 0;
      cyc  = 0;
      while (got < need) begin
         @(negedge clk_i);
         if (row.gap[cyc % 4]) begin
            make_sample(row.mode, re, im);
            en_i = 1'b1;
            re_i = re;
            im_i = im;
            model_sample(re, im, row.clog);
            got++;
         end else begin
            // Junk that must be ignored
            en_i = 1'b0;
            re_i = 4'b0101;
            im_i = 4'b0011;
         end
         cyc++;
      end
      @(negedge clk_i);
      en_i = 1'b0;
   endtask

   task automatic check_bank(input logic [1:0] mode, input logic [3:0] clog,
                             input logic [1:0] ovf);
      data_t d;
      int    c;
      for (int k = 0; k < NUM_PAIRS; k++) begin
         bus_read(addr_t'(ADR_COS_BASE + k), d);
         check_value($sformatf("cos[%0d]", k), 32'(d), 32'(exp_cos[k][15:0]));
         // Constant patterns give 2 x 2^count_log and antenna 0 negates its pairs
         if (mode == MODE_ONES || mode == MODE_INV0) begin
            c = 2 << clog;
            if (mode == MODE_INV0 && ANT_A[k] == 0)
               c = -c;
            check_value($sformatf("cos[%0d] pattern", k), 32'(d), 32'(c[15:0]));
         end
         bus_read(addr_t'(ADR_SIN_BASE + k), d);
         check_value($sformatf("sin[%0d]", k), 32'(d), 32'(exp_sin[k][15:0]));
         if (mode == MODE_ONES || mode == MODE_INV0)
            check_value($sformatf("sin[%0d] pattern", k), 32'(d), 32'h0);
         if (mode == MODE_LFSR && exp_sin[k] < 0)
            saw_neg_sin = 1'b1;
      end
      bus_read(ADR_STATUS, d);
      check_value("status", 32'(d), 32'({m_frames[7:0], 6'b0, m_ovf_sin, m_ovf_cos}));
      check_value("overflow_cos_o", 32'(overflow_cos_o), 32'(ovf[0]));
      check_value("overflow_sin_o", 32'(overflow_sin_o), 32'(ovf[1]));
   endtask

   // Writes off the register addresses must do nothing
   task automatic check_ignored_writes(input row_t row);
      data_t d;
      addr_t holes [8];
      holes = '{5'd6, 5'd7, 5'd14, 5'd15, 5'd18, 5'd19, 5'd25, 5'd31};
      bus_write(ADR_COS_BASE, 16'h1234);
      bus_write(addr_t'(ADR_SIN_BASE + 1), 16'h5678);
      for (int i = 0; i < 8; i++)
         bus_write(holes[i], 16'h0000);
      check_bank(row.mode, row.clog, row.ovf);
      bus_read(ADR_COUNT_LOG, d);
      check_value("count_log", 32'(d), 32'(row.clog));
      for (int i = 0; i < 8; i++) begin
         bus_read(holes[i], d);
         check_value($sformatf("unmapped[%0d]", holes[i]), 32'(d), 32'h0);
      end
   endtask

   // ----------------------------------------------------------------------
   // Watchdog
   // ----------------------------------------------------------------------
   initial begin
      #(run_cycles() * CLK_PERIOD * 2);
      $display("watchdog expired before the tests finished");
      stop_on_failure();
   end

   // ----------------------------------------------------------------------
   // Main sequence
   // ----------------------------------------------------------------------
   initial begin
      data_t d;
      rst   = 1'b1;
      cyc_i = 1'b0;
      stb_i = 1'b0;
      we_i  = 1'b0;
      adr_i = '0;
      dat_i = '0;
      en_i  = 1'b0;
      re_i  = '0;
      im_i  = '0;
      m_frames    = 0;
      m_ovf_cos   = 1'b0;
      m_ovf_sin   = 1'b0;
      saw_neg_sin = 1'b0;
      model_restart();
      for (int k = 0; k < NUM_PAIRS; k++) begin
         exp_cos[k] = 0;
         exp_sin[k] = 0;
      end
      repeat (10) @(posedge clk_i);
      @(negedge clk_i);
      rst = 1'b0;

      // Reset values
      bus_read(ADR_COUNT_LOG, d);
      check_value("count_log", 32'(d), 32'd4);
      check_bank(MODE_NONE, 4'd0, 2'b00);

      for (int r = 0; r < NUM_ROWS; r++) begin
         bus_write(ADR_COUNT_LOG, data_t'(ROWS[r].clog));
         model_restart();
         bus_read(ADR_COUNT_LOG, d);
         check_value("count_log", 32'(d), 32'(ROWS[r].clog));
         feed_row(ROWS[r]);
         check_bank(ROWS[r].mode, ROWS[r].clog, ROWS[r].ovf);
         if (ROWS[r].ovf != 2'b00) begin
            // Stray writes while the sticky flags are up
            check_ignored_writes(ROWS[r]);
            // Status write clears sticky flags
            bus_write(ADR_STATUS, 16'h0);
            m_ovf_cos = 1'b0;
            m_ovf_sin = 1'b0;
            check_bank(ROWS[r].mode, ROWS[r].clog, 2'b00);
         end
      end

      if (!saw_neg_sin) begin
         $display("LFSR rows never produced a negative sine visibility");
         stop_on_failure();
      end else begin
         $display("Testbench passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* project.f */
design/correlator_pkg.sv
design/correlator_block.sv
design/visibility_bank.sv
design/correlator_regs.sv
design/bus_interface.sv
design/tart_correlator.sv
tests/tb_correlator.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0 -Wno-fatal
TOP       ?= tb_correlator
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
